/* hdl/jesd_tx_pkg.sv */
package jesd_tx_pkg;

  // One character on the parallel side, either user data or a control character
  typedef logic [7:0] octet_t;

  // One 10-bit code group for the serializer, bit 0 (a) goes out first
  typedef logic [9:0] code_t;

  // Code group sync state of the transmit link
  typedef enum logic {
    cgs,  // Commas until the receiver reports code group sync
    data  // User octets pass through
  } link_state_t;

  // With charisk set this is K28.5, the comma the receiver locks onto
  localparam octet_t k28_5 = 8'hbc;

endpackage

/* hdl/jesd_8b10b_encoder.sv */
`timescale 1ns/1ns

module jesd_8b10b_encoder
  import jesd_tx_pkg::*;
(
  input  octet_t in_char,
  input  logic   in_charisk,
  input  logic   in_disparity,  // 0 is negative running disparity
  output code_t  out_char,
  output logic   out_disparity
);

  logic [4:0] x;       // EDCBA
  logic [2:0] y;       // HGF
  logic [5:0] tab6;    // abcdei for negative disparity, a is the MSB here
  logic [3:0] tab4;    // fghj for negative disparity, f is the MSB here
  logic       unbal6;
  logic       bal4;
  logic       flip6;
  logic       flip4;
  logic       rd_mid;  // Running disparity between the two sub-blocks
  logic       use_a7;
  logic [5:0] abcdei;
  logic [3:0] fghj;

  assign x = in_char[4:0];
  assign y = in_char[7:5];

  // 5b/6b table, negative disparity column
  always_comb begin
    if (in_charisk) begin
      tab6 = 6'b001111;  // K.28 is the only control code used on this link
    end else begin
      case (x)
        5'd0:    tab6 = 6'b100111;
        5'd1:    tab6 = 6'b011101;
        5'd2:    tab6 = 6'b101101;
        5'd3:    tab6 = 6'b110001;
        5'd4:    tab6 = 6'b110101;
        5'd5:    tab6 = 6'b101001;
        5'd6:    tab6 = 6'b011001;
        5'd7:    tab6 = 6'b111000;
        5'd8:    tab6 = 6'b111001;
        5'd9:    tab6 = 6'b100101;
        5'd10:   tab6 = 6'b010101;
        5'd11:   tab6 = 6'b110100;
        5'd12:   tab6 = 6'b001101;
        5'd13:   tab6 = 6'b101100;
        5'd14:   tab6 = 6'b011100;
        5'd15:   tab6 = 6'b010111;
        5'd16:   tab6 = 6'b011011;
        5'd17:   tab6 = 6'b100011;
        5'd18:   tab6 = 6'b010011;
        5'd19:   tab6 = 6'b110010;
        5'd20:   tab6 = 6'b001011;
        5'd21:   tab6 = 6'b101010;
        5'd22:   tab6 = 6'b011010;
        5'd23:   tab6 = 6'b111010;
        5'd24:   tab6 = 6'b110011;
        5'd25:   tab6 = 6'b100110;
        5'd26:   tab6 = 6'b010110;
        5'd27:   tab6 = 6'b110110;
        5'd28:   tab6 = 6'b001110;
        5'd29:   tab6 = 6'b101110;
        5'd30:   tab6 = 6'b011110;
        default: tab6 = 6'b101011;
      endcase
    end
  end

  // Unbalanced codes and D.7 are complemented when the disparity is positive
  assign unbal6 = ($countones(tab6) != 3);
  assign flip6  = in_disparity && (unbal6 || (x == 5'd7));
  assign abcdei = flip6 ? ~tab6 : tab6;
  assign rd_mid = in_disparity ^ unbal6;

  // The alternate 7 avoids a run of five equal bits across the sub-block border
  assign use_a7 = (y == 3'd7) &&
                  (in_charisk ||
                   (!rd_mid && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
                   (rd_mid && (x == 5'd11 || x == 5'd13 || x == 5'd14)));

  always_comb begin
    case (y)
      3'd0:    tab4 = 4'b1011;
      3'd1:    tab4 = 4'b1001;
      3'd2:    tab4 = 4'b0101;
      3'd3:    tab4 = 4'b1100;
      3'd4:    tab4 = 4'b1101;
      3'd5:    tab4 = 4'b1010;
      3'd6:    tab4 = 4'b0110;
      default: tab4 = use_a7 ? 4'b0111 : 4'b1110;
    endcase
  end

  assign bal4 = ($countones(tab4) == 2);

  // K.28 also complements its balanced sub-blocks, but after a negative middle disparity
  assign flip4 = rd_mid ? (!bal4 || (y == 3'd3))
                        : (in_charisk && bal4 && (y != 3'd3));
  assign fghj  = flip4 ? ~tab4 : tab4;

  assign out_disparity = rd_mid ^ !bal4;

  // Tables are written a-first, the code group is sent from bit 0
  always_comb begin
    for (int b = 0; b < 6; b++) begin
      out_char[b] = abcdei[5-b];
    end
    for (int b = 0; b < 4; b++) begin
      out_char[6+b] = fghj[3-b];
    end
  end

endmodule

/* hdl/jesd_tx_link_framer.sv */
`timescale 1ns/1ns

module jesd_tx_link_framer
  import jesd_tx_pkg::*;
#(
  parameter int num_lanes       = 2,
  parameter int data_path_width = 4
) (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   sync,
  input  octet_t [num_lanes*data_path_width-1:0] tx_data,
  output logic                                   tx_ready,
  output octet_t [num_lanes*data_path_width-1:0] fr_char,
  output logic   [num_lanes*data_path_width-1:0] fr_charisk
);

  localparam int num_octets = num_lanes * data_path_width;

  link_state_t state;
  link_state_t state_next;

  // Sync is already a synchronized level from the receiver side
  always_comb begin
    state_next = state;
    case (state)
      cgs: begin
        if (sync) begin
          state_next = data;
        end
      end
      data: begin
        if (!sync) begin
          state_next = cgs;  // Receiver lost lock, go back to commas
        end
      end
      default: begin
        state_next = cgs;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= cgs;
    end else begin
      state <= state_next;
    end
  end

  assign tx_ready = (state == data);  // Straight from the state register

  // Upstream octets are taken only in cycles with tx_ready high
  always_ff @(posedge clk) begin
    if (reset) begin
      fr_char    <= {num_octets{k28_5}};
      fr_charisk <= '1;
    end else if (tx_ready) begin
      fr_char    <= tx_data;
      fr_charisk <= '0;
    end else begin
      fr_char    <= {num_octets{k28_5}};
      fr_charisk <= '1;
    end
  end

  // A drop of tx_ready must come from a sync loss or a reset one edge earlier
  a_ready_fall: assert property (
    @(posedge clk) $fell(tx_ready) |-> ($past(!sync) || $past(reset))
  );

endmodule

/* hdl/jesd_tx_scrambler.sv */
`timescale 1ns/1ns

module jesd_tx_scrambler
  import jesd_tx_pkg::*;
#(
  parameter int num_lanes       = 2,
  parameter int data_path_width = 4
) (
  input  logic                                   clk,
  input  logic                                   reset,
  input  octet_t [num_lanes*data_path_width-1:0] fr_char,
  input  logic   [num_lanes*data_path_width-1:0] fr_charisk,
  output octet_t [num_lanes*data_path_width-1:0] sc_char,
  output logic   [num_lanes*data_path_width-1:0] sc_charisk
);

  localparam int num_octets = num_lanes * data_path_width;

  // Bit k holds the scrambled bit sent k+1 positions earlier on that lane
  logic [14:0]             lfsr      [num_lanes];
  logic [14:0]             lfsr_next [num_lanes];
  octet_t [num_octets-1:0] scr_char;

  // 1 + x^14 + x^15, fed back from the scrambled output
  always_comb begin
    logic [14:0] s;
    int          j;
    for (int l = 0; l < num_lanes; l++) begin
      s = lfsr[l];
      for (int i = 0; i < data_path_width; i++) begin
        j = l * data_path_width + i;
        scr_char[j] = fr_char[j];
        if (!fr_charisk[j]) begin  // Control characters keep their value and the state
          for (int b = 7; b >= 0; b--) begin
            scr_char[j][b] = fr_char[j][b] ^ s[13] ^ s[14];
            s = {s[13:0], scr_char[j][b]};
          end
        end
      end
      lfsr_next[l] = s;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int l = 0; l < num_lanes; l++) begin
        lfsr[l] <= '1;
      end
      sc_char    <= {num_octets{k28_5}};
      sc_charisk <= '1;
    end else begin
      lfsr       <= lfsr_next;
      sc_char    <= scr_char;
      sc_charisk <= fr_charisk;  // Flags stay aligned with their octets
    end
  end

endmodule

/* hdl/jesd_soft_pcs_tx.sv */
`timescale 1ns/1ns

module jesd_soft_pcs_tx
  import jesd_tx_pkg::*;
#(
  parameter int num_lanes       = 2,
  parameter int data_path_width = 4,
  parameter bit invert_outputs  = 1'b0
) (
  input  logic                                   clk,
  input  logic                                   reset,
  input  octet_t [num_lanes*data_path_width-1:0] sc_char,
  input  logic   [num_lanes*data_path_width-1:0] sc_charisk,
  output code_t  [num_lanes*data_path_width-1:0] data
);

  localparam int num_octets = num_lanes * data_path_width;

  logic [num_lanes-1:0]   disparity;       // Running disparity per lane, 0 is negative
  logic [num_lanes-1:0]   disparity_last;  // Disparity after the lane's last octet
  code_t [num_octets-1:0] enc_code;
  code_t [num_octets-1:0] code_pol;

  for (genvar lane = 0; lane < num_lanes; lane++) begin : g_lane
    logic [data_path_width:0] chain;

    assign chain[0]             = disparity[lane];
    assign disparity_last[lane] = chain[data_path_width];

    // Octet 0 goes out first, so the disparity ripples upward through the lane
    for (genvar i = 0; i < data_path_width; i++) begin : g_octet
      localparam int j = lane * data_path_width + i;

      jesd_8b10b_encoder u_enc (
        .in_char       (sc_char[j]),
        .in_charisk    (sc_charisk[j]),
        .in_disparity  (chain[i]),
        .out_char      (enc_code[j]),
        .out_disparity (chain[i+1])
      );
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      disparity <= '0;
    end else begin
      disparity <= disparity_last;
    end
  end

  // Polarity swap for boards with crossed differential pairs
  assign code_pol = invert_outputs ? ~enc_code : enc_code;

  always_ff @(posedge clk) begin
    data <= code_pol;
  end

  // Any valid code group, inverted or not, is balanced to within one bit pair
  for (genvar j = 0; j < num_octets; j++) begin : g_chk
    a_code_weight: assert property (
      @(posedge clk) disable iff (reset) $countones(data[j]) inside {4, 5, 6}
    );
  end

endmodule

/* hdl/jesd_tx_top.sv */
`timescale 1ns/1ns

module jesd_tx_top
  import jesd_tx_pkg::*;
#(
  parameter int num_lanes       = 2,
  parameter int data_path_width = 4,
  parameter bit invert_outputs  = 1'b0
) (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   sync,
  input  octet_t [num_lanes*data_path_width-1:0] tx_data,
  output logic                                   tx_ready,
  output code_t  [num_lanes*data_path_width-1:0] data
);

  localparam int num_octets = num_lanes * data_path_width;

  octet_t [num_octets-1:0] fr_char;
  logic   [num_octets-1:0] fr_charisk;
  octet_t [num_octets-1:0] sc_char;
  logic   [num_octets-1:0] sc_charisk;

  // Commas or user octets, one cycle
  jesd_tx_link_framer #(
    .num_lanes       (num_lanes),
    .data_path_width (data_path_width)
  ) u_link_framer (
    .clk        (clk),
    .reset      (reset),
    .sync       (sync),
    .tx_data    (tx_data),
    .tx_ready   (tx_ready),
    .fr_char    (fr_char),
    .fr_charisk (fr_charisk)
  );

  jesd_tx_scrambler #(
    .num_lanes       (num_lanes),
    .data_path_width (data_path_width)
  ) u_scrambler (
    .clk        (clk),
    .reset      (reset),
    .fr_char    (fr_char),
    .fr_charisk (fr_charisk),
    .sc_char    (sc_char),
    .sc_charisk (sc_charisk)
  );

  jesd_soft_pcs_tx #(
    .num_lanes       (num_lanes),
    .data_path_width (data_path_width),
    .invert_outputs  (invert_outputs)
  ) u_soft_pcs (
    .clk        (clk),
    .reset      (reset),
    .sc_char    (sc_char),
    .sc_charisk (sc_charisk),
    .data       (data)
  );

endmodule

/* sim/tb_jesd_tx_ref.svh */
`ifndef TB_JESD_TX_REF_SVH
`define TB_JESD_TX_REF_SVH

// Stimulus generator, one step of a 32-bit LCG
function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

// 5b/6b sub-block in the negative disparity column, written abcdei
function automatic logic [5:0] code6_neg(input logic [4:0] x);
  case (x)
    5'd0:    return 6'b100111;
    5'd1:    return 6'b011101;
    5'd2:    return 6'b101101;
    5'd3:    return 6'b110001;
    5'd4:    return 6'b110101;
    5'd5:    return 6'b101001;
    5'd6:    return 6'b011001;
    5'd7:    return 6'b111000;
    5'd8:    return 6'b111001;
    5'd9:    return 6'b100101;
    5'd10:   return 6'b010101;
    5'd11:   return 6'b110100;
    5'd12:   return 6'b001101;
    5'd13:   return 6'b101100;
    5'd14:   return 6'b011100;
    5'd15:   return 6'b010111;
    5'd16:   return 6'b011011;
    5'd17:   return 6'b100011;
    5'd18:   return 6'b010011;
    5'd19:   return 6'b110010;
    5'd20:   return 6'b001011;
    5'd21:   return 6'b101010;
    5'd22:   return 6'b011010;
    5'd23:   return 6'b111010;
    5'd24:   return 6'b110011;
    5'd25:   return 6'b100110;
    5'd26:   return 6'b010110;
    5'd27:   return 6'b110110;
    5'd28:   return 6'b001110;
    5'd29:   return 6'b101110;
    5'd30:   return 6'b011110;
    default: return 6'b101011;
  endcase
endfunction

// Code group for one octet, bit 0 holds a, the first bit on the line
function automatic code_t encode_8b10b(input octet_t c, input logic k, input logic rd);
  logic [4:0] x;
  logic [2:0] y;
  logic [5:0] s6;
  logic [3:0] s4;
  logic       rd_mid;
  logic       alt7;
  code_t      code;
  x  = c[4:0];
  y  = c[7:5];
  s6 = k ? 6'b001111 : code6_neg(x);
  if (rd && ($countones(s6) != 3 || x == 5'd7)) begin
    s6 = ~s6;
  end
  rd_mid = ($countones(s6) == 3) ? rd : ($countones(s6) > 3);
  alt7 = (!rd_mid && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
         (rd_mid && (x == 5'd11 || x == 5'd13 || x == 5'd14));
  if (k) begin
    case (y)
      3'd0:    s4 = 4'b1011;
      3'd1:    s4 = 4'b0110;
      3'd2:    s4 = 4'b1010;
      3'd3:    s4 = 4'b1100;
      3'd4:    s4 = 4'b1101;
      3'd5:    s4 = 4'b0101;
      3'd6:    s4 = 4'b1001;
      default: s4 = 4'b0111;
    endcase
    if (rd_mid) begin
      s4 = ~s4;  // Every control 3b/4b form is the complement of the other
    end
  end else begin
    case (y)
      3'd0:    s4 = 4'b1011;
      3'd1:    s4 = 4'b1001;
      3'd2:    s4 = 4'b0101;
      3'd3:    s4 = 4'b1100;
      3'd4:    s4 = 4'b1101;
      3'd5:    s4 = 4'b1010;
      3'd6:    s4 = 4'b0110;
      default: s4 = alt7 ? 4'b0111 : 4'b1110;
    endcase
    if (rd_mid && ($countones(s4) != 2 || y == 3'd3)) begin
      s4 = ~s4;
    end
  end
  for (int b = 0; b < 6; b++) begin
    code[b] = s6[5-b];
  end
  for (int b = 0; b < 4; b++) begin
    code[6+b] = s4[3-b];
  end
  return code;
endfunction

// A code group with more ones than zeros leaves the disparity positive
function automatic logic next_disparity(input code_t code, input logic rd);
  int ones;
  ones = $countones(code);
  if (ones > 5) begin
    return 1'b1;
  end else if (ones < 5) begin
    return 1'b0;
  end
  return rd;
endfunction

// Scrambled octet from the 15 bits sent before it, newest bit in hist[0]
function automatic octet_t scramble_octet(input octet_t d, input logic [14:0] hist);
  logic [22:0] w;
  w = {hist, 8'h00};
  for (int n = 7; n >= 0; n--) begin
    w[n] = d[n] ^ w[n+14] ^ w[n+15];  // Taps 14 and 15 bits back
  end
  return w[7:0];
endfunction

`endif

/* sim/tb_jesd_tx.sv */
`timescale 1ns/1ns

module tb_jesd_tx
  import jesd_tx_pkg::*;
();

  localparam int num_lanes       = 2;
  localparam int data_path_width = 4;
  localparam int num_octets      = num_lanes * data_path_width;

  localparam int reset_cycles  = 2;
  localparam int cgs_cycles    = 12;
  localparam int data_cycles   = 200;
  localparam int loss_cycles   = 5;
  localparam int resync_cycles = 150;
  localparam int drain_cycles  = 6;
  localparam int total_cycles  = reset_cycles + cgs_cycles + data_cycles + loss_cycles +
                                 resync_cycles + drain_cycles;
  localparam int cycle_limit   = total_cycles + 20;

  logic                   clk = 1'b0;
  logic                   reset;
  logic                   sync;
  octet_t [num_octets-1:0] tx_data;
  logic                   tx_ready;
  logic                   tx_ready_inv;
  code_t  [num_octets-1:0] dut_data;
  code_t  [num_octets-1:0] dut_data_inv;

  link_state_t exp_state;               // Framer state after the last edge
  logic [14:0] scr_hist [num_lanes];
  logic        ref_rd [num_lanes];      // 0 is negative running disparity
  code_t       exp_line [3][num_octets];
  logic        line_valid [3];
  logic [31:0] lcg_state;
  int          code_errors;
  int          state_errors;
  int          cycle_count = 0;

  `include "tb_jesd_tx_ref.svh"

  jesd_tx_top #(
    .num_lanes       (num_lanes),
    .data_path_width (data_path_width),
    .invert_outputs  (1'b0)
  ) u_jesd_tx_top (
    .clk      (clk),
    .reset    (reset),
    .sync     (sync),
    .tx_data  (tx_data),
    .tx_ready (tx_ready),
    .data     (dut_data)
  );

  // Same link with crossed lane polarity
  jesd_tx_top #(
    .num_lanes       (num_lanes),
    .data_path_width (data_path_width),
    .invert_outputs  (1'b1)
  ) u_jesd_tx_top_inv (
    .clk      (clk),
    .reset    (reset),
    .sync     (sync),
    .tx_data  (tx_data),
    .tx_ready (tx_ready_inv),
    .data     (dut_data_inv)
  );

  initial begin
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Run stopped after %0d cycles before the tests were complete", cycle_count);
      $display("sim failed");
      $finish;
    end
  end

  task automatic check_code(input string name, input int idx, input code_t expected,
                            input code_t actual);
    if (actual !== expected) begin
      code_errors++;
      $display("[ERROR] %0t %s[%0d] expected %h actual %h", $time, name, idx, expected, actual);
    end
  endtask

  task automatic check_state(input string name, input link_state_t expected,
                             input link_state_t actual);
    if (actual !== expected) begin
      state_errors++;
      $display("[ERROR] %0t %s expected %b actual %b", $time, name, expected, actual);
    end
  endtask

  // Framer word for the coming edge, through the scrambler and encoder models
  task automatic model_word(input int slot, input logic pass_data);
    octet_t c;
    logic   k;
    int     j;
    for (int l = 0; l < num_lanes; l++) begin
      for (int i = 0; i < data_path_width; i++) begin
        j = l * data_path_width + i;
        c = pass_data ? tx_data[j] : k28_5;
        k = !pass_data;
        if (!k) begin
          c = scramble_octet(c, scr_hist[l]);
          scr_hist[l] = {scr_hist[l][6:0], c};
        end
        exp_line[slot][j] = encode_8b10b(c, k, ref_rd[l]);
        ref_rd[l] = next_disparity(exp_line[slot][j], ref_rd[l]);
      end
    end
    line_valid[slot] = 1'b1;
  endtask

  // New octets only once the previous ones were taken
  task automatic drive_cycle(input logic sync_level);
    logic was_ready;
    was_ready = tx_ready;
    @(posedge clk);
    #10;
    sync = sync_level;
    if (was_ready) begin
      for (int j = 0; j < num_octets; j++) begin
        lcg_state = lcg_next(lcg_state);
        tx_data[j] = lcg_state[23:16];
      end
    end
  endtask

  // Mid-cycle, outputs of the last edge and inputs for the next one are both stable
  always @(negedge clk) begin
    if (line_valid[0]) begin
      for (int i = 0; i < num_octets; i++) begin
        check_code("data", i, exp_line[0][i], dut_data[i]);
        check_code("data_inv", i, ~exp_line[0][i], dut_data_inv[i]);
      end
    end
    check_state("tx_ready", exp_state, link_state_t'(tx_ready));
    check_state("tx_ready_inv", exp_state, link_state_t'(tx_ready_inv));
    if (reset) begin
      exp_state = cgs;
      for (int l = 0; l < num_lanes; l++) begin
        scr_hist[l] = '1;
        ref_rd[l]   = 1'b0;
      end
      line_valid[0] = 1'b0;  // Output of the reset edge itself
      model_word(1, 1'b0);   // Commas still in the scrambler and PCS registers
      model_word(2, 1'b0);
    end else begin
      for (int s = 0; s < 2; s++) begin
        line_valid[s] = line_valid[s+1];
        for (int i = 0; i < num_octets; i++) begin
          exp_line[s][i] = exp_line[s+1][i];
        end
      end
      model_word(2, exp_state == data);
      exp_state = sync ? data : cgs;  // Same rule from either state
    end
  end

  initial begin
    reset        = 1'b1;
    sync         = 1'b0;
    exp_state    = cgs;
    code_errors  = 0;
    state_errors = 0;
    lcg_state    = 32'd64;
    for (int s = 0; s < 3; s++) begin
      line_valid[s] = 1'b0;
    end
    for (int j = 0; j < num_octets; j++) begin
      lcg_state = lcg_next(lcg_state);
      tx_data[j] = lcg_state[23:16];
    end
    repeat (reset_cycles) @(posedge clk);
    #10;
    reset = 1'b0;
    repeat (cgs_cycles) drive_cycle(1'b0);     // Commas only
    repeat (data_cycles) drive_cycle(1'b1);
    repeat (loss_cycles) drive_cycle(1'b0);    // Receiver loses lock
    repeat (resync_cycles) drive_cycle(1'b1);
    repeat (drain_cycles) drive_cycle(1'b0);
    $display("Errors: %0d code group, %0d link state", code_errors, state_errors);
    if (code_errors + state_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+sim
hdl/jesd_tx_pkg.sv
hdl/jesd_8b10b_encoder.sv
hdl/jesd_tx_link_framer.sv
hdl/jesd_tx_scrambler.sv
hdl/jesd_soft_pcs_tx.sv
hdl/jesd_tx_top.sv
sim/tb_jesd_tx.sv
